// ==== sim/tinker_core_asserts.sv ====
module tinker_core_asserts import tinker_pkg::*; (
    input logic            clk,
    input logic            reset,
    input logic            boot,
    input logic            retire_valid,
    input logic [xlen-1:0] retire_data,
    input logic            hlt
);
    timeunit 1ns;
    timeprecision 1ps;

    // halt flag sticky until reset
    hlt_sticky: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
        else $error("hlt fell without a reset");

    // no write-back while loading or once halted
    retire_quiet: assert property (@(posedge clk) disable iff (reset)
        (boot || hlt) |-> !retire_valid)
        else $error("retire_valid high during boot or after hlt");

    // retired data never has unknown bits
    retire_known: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> !$isunknown(retire_data))
        else $error("retire_data has unknown bits on a retire");

endmodule

bind tinker_core tinker_core_asserts i_asserts (
    .clk(clk), .reset(reset), .boot(boot), .retire_valid(retire_valid),
    .retire_data(retire_data), .hlt(hlt)
);

// ==== sim/tinker_core_tb.sv ====
module tinker_core_tb import tinker_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int              imem_addr_bits = 12;
    localparam logic [xlen-1:0] reset_pc       = 64'h2000;
    localparam int              prog_len       = 38;
    // run bound in cycles after boot drops
    localparam int              cycle_limit    = 40 + 6 * prog_len;

    logic                      clk;
    logic                      reset;
    logic                      boot;
    logic                      imem_we;
    logic [imem_addr_bits-1:0] imem_addr;
    logic [instr_bits-1:0]     imem_wdata;
    logic                      retire_valid;
    logic [reg_bits-1:0]       retire_rd;
    logic [xlen-1:0]           retire_data;
    logic                      hlt;

    // program table with one row per word
    logic [instr_bits-1:0] prog_word    [prog_len];
    logic                  prog_retires [prog_len];
    logic [reg_bits-1:0]   prog_rd      [prog_len];
    logic [xlen-1:0]       prog_val     [prog_len];

    tinker_core #(.imem_addr_bits(imem_addr_bits), .reset_pc(reset_pc)) i_dut (
        .clk(clk), .reset(reset), .boot(boot), .imem_we(imem_we),
        .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .retire_valid(retire_valid), .retire_rd(retire_rd),
        .retire_data(retire_data), .hlt(hlt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // opcode, rd, rs, rt, L from the top bit down
    function automatic logic [instr_bits-1:0] encode(input int op, input int rd, input int rs,
                                                     input int rt, input int l);
        return {op[4:0], rd[4:0], rs[4:0], rt[4:0], l[11:0]};
    endfunction

    task automatic set_entry(input int idx, input logic [instr_bits-1:0] word,
                             input logic retires, input int rd, input logic [xlen-1:0] value);
        prog_word[idx]    = word;
        prog_retires[idx] = retires;
        prog_rd[idx]      = rd[4:0];
        prog_val[idx]     = value;
    endtask

    // first row at or after from that writes a register
    function automatic int next_retire(input int from);
        for (int i = from; i < prog_len; i++) begin
            if (prog_retires[i]) begin
                return i;
            end
        end
        return prog_len;
    endfunction

    task automatic stop_with_fail(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic fill_program();
        // ALU ops with forwarding at distance 1 to 3 on rs and rt
        set_entry(0, encode(op_addi, 1, 0, 0, 12'h005), 1'b1, 1, 64'h5);
        set_entry(1, encode(op_addi, 2, 0, 0, 12'hffd), 1'b1, 2, 64'hffff_ffff_ffff_fffd);
        set_entry(2, encode(op_add, 3, 1, 2, 0), 1'b1, 3, 64'h2);
        set_entry(3, encode(op_sub, 4, 3, 1, 0), 1'b1, 4, 64'hffff_ffff_ffff_fffd);
        set_entry(4, encode(op_xor, 5, 4, 2, 0), 1'b1, 5, 64'h0);
        // rs three back and rt two back
        set_entry(5, encode(op_or, 6, 3, 4, 0), 1'b1, 6, 64'hffff_ffff_ffff_ffff);
        set_entry(6, encode(op_and, 7, 6, 1, 0), 1'b1, 7, 64'h5);
        set_entry(7, encode(op_not, 8, 7, 0, 0), 1'b1, 8, 64'hffff_ffff_ffff_fffa);
        // shifts then rd accumulate right behind
        set_entry(8, encode(op_shftli, 9, 1, 0, 4), 1'b1, 9, 64'h50);
        set_entry(9, encode(op_shftri, 9, 9, 0, 2), 1'b1, 9, 64'h14);
        set_entry(10, encode(op_addi, 9, 0, 0, 12'h7ff), 1'b1, 9, 64'h813);
        set_entry(11, encode(op_subi, 9, 0, 0, 12'h013), 1'b1, 9, 64'h800);
        set_entry(12, encode(op_shftl, 11, 1, 3, 0), 1'b1, 11, 64'h14);
        // logical shift right of ...fffa by 5
        set_entry(13, encode(op_shftr, 12, 8, 1, 0), 1'b1, 12, 64'h07ff_ffff_ffff_ffff);
        set_entry(14, encode(op_mov, 13, 12, 0, 0), 1'b1, 13, 64'h07ff_ffff_ffff_ffff);
        set_entry(15, encode(op_mov_l, 13, 0, 0, 12'habc), 1'b1, 13, 64'h07ff_ffff_ffff_fabc);
        // rd reads at distance 2 and 3
        set_entry(16, encode(op_addi, 1, 0, 0, 1), 1'b1, 1, 64'h6);
        set_entry(17, encode(op_mov, 14, 9, 0, 0), 1'b1, 14, 64'h800);
        set_entry(18, encode(op_addi, 1, 0, 0, 2), 1'b1, 1, 64'h8);
        set_entry(19, encode(op_subi, 14, 0, 0, 1), 1'b1, 14, 64'h7ff);
        set_entry(20, encode(op_xor, 15, 1, 14, 0), 1'b1, 15, 64'h7f7);
        set_entry(21, encode(op_addi, 1, 0, 0, 12'h010), 1'b1, 1, 64'h18);
        // branch target built as 2000h + 4 * 29
        set_entry(22, encode(op_addi, 10, 0, 0, 1), 1'b1, 10, 64'h1);
        set_entry(23, encode(op_shftli, 10, 10, 0, 13), 1'b1, 10, 64'h2000);
        set_entry(24, encode(op_mov_l, 10, 0, 0, 12'h074), 1'b1, 10, 64'h2074);
        // taken brnz skips rows 26 to 28
        set_entry(25, encode(op_brnz, 10, 1, 0, 0), 1'b0, 0, 0);
        set_entry(26, encode(op_addi, 1, 0, 0, 12'h100), 1'b0, 0, 0);
        set_entry(27, encode(op_addi, 20, 0, 0, 1), 1'b0, 0, 0);
        set_entry(28, encode(op_addi, 21, 0, 0, 1), 1'b0, 0, 0);
        // r0 is zero so this falls through
        set_entry(29, encode(op_brnz, 10, 0, 0, 0), 1'b0, 0, 0);
        set_entry(30, encode(op_addi, 16, 0, 0, 7), 1'b1, 16, 64'h7);
        // jump 12 bytes ahead over rows 32 and 33
        set_entry(31, encode(op_jump_rel2, 0, 0, 0, 12'h00c), 1'b0, 0, 0);
        set_entry(32, encode(op_addi, 16, 0, 0, 12'h100), 1'b0, 0, 0);
        set_entry(33, encode(op_addi, 22, 0, 0, 1), 1'b0, 0, 0);
        set_entry(34, encode(op_add, 17, 16, 1, 0), 1'b1, 17, 64'h1f);
        set_entry(35, encode(op_halt, 0, 0, 0, 0), 1'b0, 0, 0);
        // rows past the halt never retire
        set_entry(36, encode(op_addi, 23, 0, 0, 1), 1'b0, 0, 0);
        set_entry(37, encode(op_addi, 24, 0, 0, 1), 1'b0, 0, 0);
    endtask

    initial begin
        int cycles;
        int pos;
        reset      = 1'b1;
        boot       = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        fill_program();
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        assert (!retire_valid && !hlt) else stop_with_fail("retire or hlt active after reset");
        // load words at reset_pc onward while boot holds fetch
        for (int i = 0; i < prog_len; i++) begin
            imem_we    = 1'b1;
            imem_addr  = imem_addr_bits'(reset_pc / 4 + xlen'(i));
            imem_wdata = prog_word[i];
            @(posedge clk);
            #2;
            assert (!retire_valid && !hlt)
                else stop_with_fail("retire or hlt active during boot");
        end
        imem_we = 1'b0;
        boot    = 1'b0;
        // retires in table order until hlt
        cycles = 0;
        pos    = next_retire(0);
        forever begin
            @(negedge clk);
            cycles++;
            if (hlt) begin
                break;
            end
            assert (cycles < cycle_limit)
                else stop_with_fail($sformatf("timeout, the core did not halt in %0d cycles",
                                              cycle_limit));
            if (retire_valid) begin
                assert (pos < prog_len)
                    else stop_with_fail($sformatf("ERR %0t: extra retire of r%0d = %h",
                                                  $time, retire_rd, retire_data));
                assert (retire_rd == prog_rd[pos] && retire_data == prog_val[pos])
                    else stop_with_fail($sformatf(
                        "ERR %0t: row %0d expected r%0d = %h, got r%0d = %h", $time, pos,
                        prog_rd[pos], prog_val[pos], retire_rd, retire_data));
                pos = next_retire(pos + 1);
            end
        end
        assert (pos == prog_len)
            else stop_with_fail($sformatf("ERR %0t: hlt rose before row %0d retired",
                                          $time, pos));
        // hold a few cycles with no late retire and hlt still up
        repeat (5) begin
            assert (!retire_valid && hlt)
                else stop_with_fail($sformatf("ERR %0t: retire or hlt drop after halt",
                                              $time));
            @(negedge clk);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== source/decode_stage.sv ====
module decode_stage import tinker_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  if_valid,
    input  logic [xlen-1:0]       if_pc,
    input  logic [instr_bits-1:0] if_instr,
    input  logic [xlen-1:0]       rs_val,
    input  logic [xlen-1:0]       rt_val,
    input  logic [xlen-1:0]       rd_val,
    output logic [reg_bits-1:0]   rs_idx,
    output logic [reg_bits-1:0]   rt_idx,
    output logic [reg_bits-1:0]   rd_idx,
    output logic                  halt_ahead,
    output logic                  id_valid,
    output logic [op_bits-1:0]    id_op,
    output logic [reg_bits-1:0]   id_rd,
    output logic [reg_bits-1:0]   id_rs,
    output logic [reg_bits-1:0]   id_rt,
    output logic [xlen-1:0]       id_imm,
    output logic                  id_rt_used,
    output logic [xlen-1:0]       id_pc,
    output logic [xlen-1:0]       id_a,
    output logic [xlen-1:0]       id_b,
    output logic [xlen-1:0]       id_d
);

    logic [op_bits-1:0]  op;
    logic [imm_bits-1:0] imm;
    logic                rt_used;

    // field slicing, register file reads go out straight from here
    assign op     = if_instr[op_lsb +: op_bits];
    assign rd_idx = if_instr[rd_lsb +: reg_bits];
    assign rs_idx = if_instr[rs_lsb +: reg_bits];
    assign rt_idx = if_instr[rt_lsb +: reg_bits];
    assign imm    = if_instr[imm_bits-1:0];

    // immediate forms, mov_L and jump rel2 take L instead of rt
    assign rt_used = !(op == op_addi || op == op_subi || op == op_shftri ||
                       op == op_shftli || op == op_mov_l || op == op_jump_rel2);

    assign halt_ahead = id_valid && id_op == op_halt;

    // ID/EX valid
    // whatever sits behind a halt is dropped here
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= if_valid && !flush && !halt_ahead;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        id_op      <= op;
        id_rd      <= rd_idx;
        id_rs      <= rs_idx;
        id_rt      <= rt_idx;
        id_imm     <= {{(xlen-imm_bits){imm[imm_bits-1]}}, imm};
        id_rt_used <= rt_used;
        id_pc      <= if_pc;
        id_a       <= rs_val;
        id_b       <= rt_val;
        id_d       <= rd_val;
    end

endmodule

// ==== source/execute_stage.sv ====
module execute_stage import tinker_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                id_valid,
    input  logic [op_bits-1:0]  id_op,
    input  logic [reg_bits-1:0] id_rd,
    input  logic [reg_bits-1:0] id_rs,
    input  logic [reg_bits-1:0] id_rt,
    input  logic [xlen-1:0]     id_imm,
    input  logic                id_rt_used,
    input  logic [xlen-1:0]     id_pc,
    input  logic [xlen-1:0]     id_a,
    input  logic [xlen-1:0]     id_b,
    input  logic [xlen-1:0]     id_d,
    input  logic                wb_valid,
    input  logic [reg_bits-1:0] wb_rd,
    input  logic [xlen-1:0]     wb_data,
    output logic                redirect,
    output logic [xlen-1:0]     target,
    output logic                ex_valid,
    output logic [op_bits-1:0]  ex_op,
    output logic [reg_bits-1:0] ex_rd,
    output logic [xlen-1:0]     ex_result,
    output logic                halt_ahead
);

    logic            ex_fwd;
    logic            live;
    logic [xlen-1:0] src_s;
    logic [xlen-1:0] src_t;
    logic [xlen-1:0] src_d;
    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    logic [xlen-1:0] result;
    logic [xlen-1:0] next_target;
    logic            writes;
    logic            taken;

    // a halt in EX/MEM carries no result
    assign ex_fwd     = ex_valid && ex_op != op_halt;
    assign halt_ahead = ex_valid && ex_op == op_halt;
    // ID/EX entry is wrong-path while a redirect is pending
    assign live       = id_valid && !redirect;

    function automatic logic [xlen-1:0] fwd(
        input logic [reg_bits-1:0] idx,
        input logic [xlen-1:0]     rf_val
    );
        // EX/MEM holds the younger writer
        if (ex_fwd && ex_rd == idx) begin
            return ex_result;
        end else if (wb_valid && wb_rd == idx) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    always_comb begin
        src_s = fwd(id_rs, id_a);
        src_t = fwd(id_rt, id_b);
        src_d = fwd(id_rd, id_d);
        // addi and subi accumulate into rd
        opa = (id_op == op_addi || id_op == op_subi) ? src_d : src_s;
        opb = id_rt_used ? src_t : id_imm;
        result      = '0;
        writes      = 1'b1;
        taken       = 1'b0;
        next_target = src_d;
        case (id_op)
            op_add, op_addi:     result = opa + opb;
            op_sub, op_subi:     result = opa - opb;
            op_and:              result = opa & opb;
            op_or:               result = opa | opb;
            op_xor:              result = opa ^ opb;
            op_not:              result = ~opa;
            op_shftr, op_shftri: result = opa >> opb;
            op_shftl, op_shftli: result = opa << opb;
            op_mov:              result = opa;
            // upper bits of rd survive
            op_mov_l:            result = {src_d[xlen-1:imm_bits], id_imm[imm_bits-1:0]};
            op_jump_rel2: begin
                writes      = 1'b0;
                taken       = 1'b1;
                next_target = id_pc + id_imm;
            end
            op_brnz: begin
                writes = 1'b0;
                taken  = src_s != '0;
            end
            default:             writes = 1'b0;
        endcase
    end

    // EX/MEM control, halt rides along with its valid bit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            redirect <= 1'b0;
            ex_valid <= 1'b0;
        end else begin
            redirect <= live && taken;
            ex_valid <= live && (writes || id_op == op_halt);
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        target    <= next_target;
        ex_op     <= id_op;
        ex_rd     <= id_rd;
        ex_result <= result;
    end

endmodule

// ==== source/fetch_stage.sv ====
module fetch_stage import tinker_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = 64'h2000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  boot,
    input  logic                  stop,
    input  logic                  redirect,
    input  logic [xlen-1:0]       target,
    input  logic [instr_bits-1:0] imem_instr,
    output logic [xlen-1:0]       pc,
    output logic                  if_valid,
    output logic [xlen-1:0]       if_pc,
    output logic [instr_bits-1:0] if_instr
);

    // pc update and IF/ID valid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc       <= reset_pc;
            if_valid <= 1'b0;
        end else if (redirect) begin
            // taken branch wins over a pending halt stop
            pc       <= target;
            if_valid <= 1'b0;
        end else if (boot || stop) begin
            // hold pc, send bubbles
            if_valid <= 1'b0;
        end else begin
            pc       <= pc + xlen'(4);
            if_valid <= 1'b1;
        end
    end

    // IF/ID payload, qualified by if_valid
    always_ff @(posedge clk) begin
        if_pc    <= pc;
        if_instr <= imem_instr;
    end

endmodule

// ==== source/instruction_memory.sv ====
module instruction_memory import tinker_pkg::*; #(
    parameter int imem_addr_bits = 12
) (
    input  logic                      clk,
    input  logic                      we,
    input  logic [imem_addr_bits-1:0] waddr,
    input  logic [instr_bits-1:0]     wdata,
    input  logic [xlen-1:0]           pc,
    output logic [instr_bits-1:0]     instr
);

    // one instruction per word
    logic [instr_bits-1:0] mem [2**imem_addr_bits];

    // program load port, used while the core is in boot
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // pc is a byte address, drop the two offset bits
    assign instr = mem[pc[imem_addr_bits+1:2]];

endmodule

// ==== source/register_file.sv ====
module register_file import tinker_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                we,
    input  logic [reg_bits-1:0] waddr,
    input  logic [xlen-1:0]     wdata,
    input  logic [reg_bits-1:0] raddr_s,
    input  logic [reg_bits-1:0] raddr_t,
    input  logic [reg_bits-1:0] raddr_d,
    output logic [xlen-1:0]     rs_val,
    output logic [xlen-1:0]     rt_val,
    output logic [xlen-1:0]     rd_val
);

    logic [xlen-1:0] regs [2**reg_bits];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_bits; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through, decode sees the value being retired this cycle
    assign rs_val = (we && waddr == raddr_s) ? wdata : regs[raddr_s];
    assign rt_val = (we && waddr == raddr_t) ? wdata : regs[raddr_t];
    assign rd_val = (we && waddr == raddr_d) ? wdata : regs[raddr_d];

endmodule

// ==== source/retire_stage.sv ====
module retire_stage import tinker_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                ex_valid,
    input  logic [op_bits-1:0]  ex_op,
    input  logic [reg_bits-1:0] ex_rd,
    input  logic [xlen-1:0]     ex_result,
    output logic                wb_valid,
    output logic [reg_bits-1:0] wb_rd,
    output logic [xlen-1:0]     wb_data,
    output logic                wb_halt,
    output logic                hlt
);

    logic               mw_valid;
    logic [op_bits-1:0] mw_op;

    // MEM/WB control, plus the sticky halt flag
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mw_valid <= 1'b0;
            hlt      <= 1'b0;
        end else begin
            mw_valid <= ex_valid;
            if (wb_halt) begin
                hlt <= 1'b1;
            end
        end
    end

    // MEM/WB payload
    always_ff @(posedge clk) begin
        mw_op   <= ex_op;
        wb_rd   <= ex_rd;
        wb_data <= ex_result;
    end

    // halt is not a register write
    assign wb_valid = mw_valid && mw_op != op_halt;
    assign wb_halt  = mw_valid && mw_op == op_halt;

endmodule

// ==== source/tinker_core.sv ====
module tinker_core import tinker_pkg::*; #(
    parameter int              imem_addr_bits = 12,
    parameter logic [xlen-1:0] reset_pc       = 64'h2000
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      boot,
    input  logic                      imem_we,
    input  logic [imem_addr_bits-1:0] imem_addr,
    input  logic [instr_bits-1:0]     imem_wdata,
    output logic                      retire_valid,
    output logic [reg_bits-1:0]       retire_rd,
    output logic [xlen-1:0]           retire_data,
    output logic                      hlt
);

    // fetch side
    logic [xlen-1:0]       pc;
    logic [instr_bits-1:0] imem_instr;
    logic                  if_valid;
    logic [xlen-1:0]       if_pc;
    logic [instr_bits-1:0] if_instr;
    logic                  stop;
    // decode and register file
    logic [reg_bits-1:0]   rs_idx, rt_idx, rd_idx;
    logic [xlen-1:0]       rs_val, rt_val, rd_val;
    logic                  id_halt_ahead;
    logic                  id_valid;
    logic [op_bits-1:0]    id_op;
    logic [reg_bits-1:0]   id_rd, id_rs, id_rt;
    logic [xlen-1:0]       id_imm;
    logic                  id_rt_used;
    logic [xlen-1:0]       id_pc, id_a, id_b, id_d;
    // execute
    logic                  redirect;
    logic [xlen-1:0]       target;
    logic                  ex_valid;
    logic [op_bits-1:0]    ex_op;
    logic [reg_bits-1:0]   ex_rd;
    logic [xlen-1:0]       ex_result;
    logic                  ex_halt_ahead;
    // write-back
    logic                  wb_valid;
    logic [reg_bits-1:0]   wb_rd;
    logic [xlen-1:0]       wb_data;
    logic                  wb_halt;

    // any halt in flight, or already taken, freezes fetch
    assign stop = id_halt_ahead || ex_halt_ahead || wb_halt || hlt;

    instruction_memory #(.imem_addr_bits(imem_addr_bits)) i_imem (
        .clk(clk), .we(imem_we), .waddr(imem_addr), .wdata(imem_wdata),
        .pc(pc), .instr(imem_instr)
    );

    fetch_stage #(.reset_pc(reset_pc)) i_fetch (
        .clk(clk), .reset(reset), .boot(boot), .stop(stop),
        .redirect(redirect), .target(target), .imem_instr(imem_instr),
        .pc(pc), .if_valid(if_valid), .if_pc(if_pc), .if_instr(if_instr)
    );

    // a taken branch flushes ID/EX too
    decode_stage i_decode (
        .clk(clk), .reset(reset), .flush(redirect),
        .if_valid(if_valid), .if_pc(if_pc), .if_instr(if_instr),
        .rs_val(rs_val), .rt_val(rt_val), .rd_val(rd_val),
        .rs_idx(rs_idx), .rt_idx(rt_idx), .rd_idx(rd_idx),
        .halt_ahead(id_halt_ahead), .id_valid(id_valid), .id_op(id_op),
        .id_rd(id_rd), .id_rs(id_rs), .id_rt(id_rt), .id_imm(id_imm),
        .id_rt_used(id_rt_used), .id_pc(id_pc),
        .id_a(id_a), .id_b(id_b), .id_d(id_d)
    );

    register_file i_regs (
        .clk(clk), .reset(reset), .we(wb_valid), .waddr(wb_rd), .wdata(wb_data),
        .raddr_s(rs_idx), .raddr_t(rt_idx), .raddr_d(rd_idx),
        .rs_val(rs_val), .rt_val(rt_val), .rd_val(rd_val)
    );

    execute_stage i_execute (
        .clk(clk), .reset(reset), .id_valid(id_valid), .id_op(id_op),
        .id_rd(id_rd), .id_rs(id_rs), .id_rt(id_rt), .id_imm(id_imm),
        .id_rt_used(id_rt_used), .id_pc(id_pc),
        .id_a(id_a), .id_b(id_b), .id_d(id_d),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .redirect(redirect), .target(target), .ex_valid(ex_valid),
        .ex_op(ex_op), .ex_rd(ex_rd), .ex_result(ex_result),
        .halt_ahead(ex_halt_ahead)
    );

    retire_stage i_retire (
        .clk(clk), .reset(reset), .ex_valid(ex_valid), .ex_op(ex_op),
        .ex_rd(ex_rd), .ex_result(ex_result),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .wb_halt(wb_halt), .hlt(hlt)
    );

    // retire report is the register write port
    assign retire_valid = wb_valid;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

// ==== source/tinker_pkg.sv ====
package tinker_pkg;

    // datapath and instruction widths
    localparam int xlen       = 64;
    localparam int instr_bits = 32;
    localparam int op_bits    = 5;
    localparam int reg_bits   = 5;
    localparam int imm_bits   = 12;

    // field positions, L sits at bit 0
    localparam int op_lsb = 27;
    localparam int rd_lsb = 22;
    localparam int rs_lsb = 17;
    localparam int rt_lsb = 12;

    // logic and shifts
    localparam logic [op_bits-1:0] op_and     = 5'b00000;
    localparam logic [op_bits-1:0] op_or      = 5'b00001;
    localparam logic [op_bits-1:0] op_xor     = 5'b00010;
    localparam logic [op_bits-1:0] op_not     = 5'b00011;
    localparam logic [op_bits-1:0] op_shftr   = 5'b00100;
    localparam logic [op_bits-1:0] op_shftri  = 5'b00101;
    localparam logic [op_bits-1:0] op_shftl   = 5'b00110;
    localparam logic [op_bits-1:0] op_shftli  = 5'b00111;
    // control flow
    localparam logic [op_bits-1:0] op_jump_rel2 = 5'b01010;
    localparam logic [op_bits-1:0] op_brnz      = 5'b01011;
    localparam logic [op_bits-1:0] op_halt      = 5'b01111;
    // moves
    localparam logic [op_bits-1:0] op_mov   = 5'b10001;
    localparam logic [op_bits-1:0] op_mov_l = 5'b10010;
    // arithmetic
    localparam logic [op_bits-1:0] op_add  = 5'b11000;
    localparam logic [op_bits-1:0] op_addi = 5'b11001;
    localparam logic [op_bits-1:0] op_sub  = 5'b11010;
    localparam logic [op_bits-1:0] op_subi = 5'b11011;

endpackage

// ==== tinker_core.f ====
source/tinker_pkg.sv
source/instruction_memory.sv
source/fetch_stage.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/retire_stage.sv
source/tinker_core.sv
sim/tinker_core_asserts.sv
sim/tinker_core_tb.sv
